// ==== Makefile ====
# Verilator build and run of the packet generator testbench.

VERILATOR ?= verilator
TOP       ?= tb_axis_packet_generator
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/100ps
PASS_MSG  ?= Test OK

SIM_BIN = $(abspath $(OBJ_DIR)/V$(TOP))

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the status comes from the search for the pass line.
run: compile
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+logic
logic/axis_types_pkg.sv
logic/pkt_gen_pkg.sv
logic/pkt_buffer.sv
logic/beat_counter.sv
logic/pkt_gen_fsm.sv
logic/beat_formatter.sv
logic/axis_packet_generator.sv
sim/tb_axis_packet_generator.sv

// ==== logic/axis_packet_generator.sv ====
// AXI4-Stream packet generator top level
// buffer, beat counter, send FSM and beat formatter.

`default_nettype none
`timescale 1ns/100ps

module axis_packet_generator
    import axis_types_pkg::*;
    import pkt_gen_pkg::*;
(
    input  wire logic       axis_packet_out,
    input  wire logic       rst,

    // host side.
    input  wire logic       wr_strobe,
    input  wire word_addr_t wr_addr,
    input  wire axis_data_t wr_data,
    input  wire logic       send_req,
    input  wire pkt_len_t   pkt_len,
    input  wire axis_user_t pkt_user,
    output logic            busy,

    // stream side.
    output logic            axis_packet_out_tvalid,
    output axis_data_t      axis_packet_out_tdata,
    output axis_keep_t      axis_packet_out_tkeep,
    output axis_user_t      axis_packet_out_tuser,
    output logic            axis_packet_out_tlast,
    input  wire logic       axis_packet_out_tready
);

    logic       accept;
    logic       advance;
    logic       last_beat;
    beat_cnt_t  beat_idx;
    axis_data_t raw_word;

    pkt_buffer u_pkt_buffer (
        .axis_packet_out (axis_packet_out),
        .wr_strobe       (wr_strobe),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        // the index never passes the last word of the buffer.
        .rd_addr         (word_addr_t'(beat_idx)),
        .rd_data         (raw_word)
    );

    beat_counter u_beat_counter (
        .axis_packet_out (axis_packet_out),
        .rst             (rst),
        .load            (accept),
        .pkt_len         (pkt_len),
        .advance         (advance),
        .beat_idx        (beat_idx),
        .last_beat       (last_beat)
    );

    pkt_gen_fsm u_pkt_gen_fsm (
        .axis_packet_out (axis_packet_out),
        .rst             (rst),
        .send_req        (send_req),
        .pkt_len         (pkt_len),
        .last_beat       (last_beat),
        .tready          (axis_packet_out_tready),
        .accept          (accept),
        .advance         (advance),
        .busy            (busy),
        .tvalid          (axis_packet_out_tvalid)
    );

    beat_formatter u_beat_formatter (
        .axis_packet_out (axis_packet_out),
        .rst             (rst),
        .accept          (accept),
        .pkt_len         (pkt_len),
        .pkt_user        (pkt_user),
        .raw_word        (raw_word),
        .last_beat       (last_beat),
        .tdata           (axis_packet_out_tdata),
        .tkeep           (axis_packet_out_tkeep),
        .tuser           (axis_packet_out_tuser),
        .tlast           (axis_packet_out_tlast)
    );

endmodule

`default_nettype wire

// ==== logic/axis_types_pkg.sv ====
// stream-side vector types
// tdata word, tkeep mask and tuser tag.

`include "pkt_gen_cfg.svh"
`default_nettype none

package axis_types_pkg;

    // one beat of tdata.
    typedef logic [`PKT_GEN_DATA_BYTES*8-1:0] axis_data_t;

    // one bit per tdata lane.
    typedef logic [`PKT_GEN_DATA_BYTES-1:0] axis_keep_t;

    // tag repeated on every beat of a packet.
    typedef logic [`PKT_GEN_USER_WIDTH-1:0] axis_user_t;

endpackage

`default_nettype wire

// ==== logic/beat_counter.sv ====
// beat counter
// beat total per packet, current beat index and the last-beat flag.

`include "pkt_gen_cfg.svh"
`default_nettype none
`timescale 1ns/100ps

module beat_counter
    import pkt_gen_pkg::*;
(
    input  wire logic     axis_packet_out,
    input  wire logic     rst,
    input  wire logic     load,
    input  wire pkt_len_t pkt_len,
    input  wire logic     advance,
    output beat_cnt_t     beat_idx,
    output logic          last_beat
);

    localparam int data_bytes = `PKT_GEN_DATA_BYTES;

    beat_cnt_t beat_total;

    always_ff @(posedge axis_packet_out) begin
        if (rst) begin
            beat_total <= '0;
            beat_idx   <= '0;
        end else if (load) begin
            // round up so that a partial final beat is counted.
            beat_total <= beat_cnt_t'((int'(pkt_len) + data_bytes - 1) / data_bytes);
            beat_idx   <= '0;
        end else if (advance) begin
            beat_idx <= beat_idx + beat_cnt_t'(1);
        end
    end

    // a zero total after reset wraps to all ones, which keeps the flag low.
    assign last_beat = (beat_idx == beat_total - beat_cnt_t'(1));

endmodule

`default_nettype wire

// ==== logic/beat_formatter.sv ====
// beat formatter
// captured tag and final-beat byte count, lane order, tkeep and tlast.

`include "pkt_gen_cfg.svh"
`default_nettype none
`timescale 1ns/100ps

module beat_formatter
    import axis_types_pkg::*;
    import pkt_gen_pkg::*;
(
    input  wire logic       axis_packet_out,
    input  wire logic       rst,
    input  wire logic       accept,
    input  wire pkt_len_t   pkt_len,
    input  wire axis_user_t pkt_user,
    input  wire axis_data_t raw_word,
    input  wire logic       last_beat,
    output axis_data_t      tdata,
    output axis_keep_t      tkeep,
    output axis_user_t      tuser,
    output logic            tlast
);

    localparam int data_bytes = `PKT_GEN_DATA_BYTES;
    localparam int cnt_w      = $clog2(data_bytes + 1);

    // packet bytes held by the final beat, 1 to data_bytes.
    logic [cnt_w-1:0] last_bytes;
    axis_user_t       user_q;

    always_ff @(posedge axis_packet_out) begin
        if (rst) begin
            last_bytes <= '0;
            user_q     <= '0;
        end else if (accept) begin
            if (int'(pkt_len) % data_bytes == 0) begin
                last_bytes <= cnt_w'(data_bytes);
            end else begin
                last_bytes <= cnt_w'(int'(pkt_len) % data_bytes);
            end
            user_q <= pkt_user;
        end
    end

    always_comb begin
        tdata = raw_word;
        tkeep = '1;
        if (`PKT_GEN_BIG_ENDIAN) begin
            for (int i = 0; i < data_bytes; i++) begin
                tdata[(data_bytes-1-i)*8 +: 8] = raw_word[i*8 +: 8];
            end
        end
        if (last_beat) begin
            tkeep = '0;
            // mark packet byte i in the lane it was moved to.
            for (int i = 0; i < data_bytes; i++) begin
                if (i < int'(last_bytes)) begin
                    if (`PKT_GEN_BIG_ENDIAN) begin
                        tkeep[data_bytes-1-i] = 1'b1;
                    end else begin
                        tkeep[i] = 1'b1;
                    end
                end
            end
        end
    end

    assign tuser = user_q;
    assign tlast = last_beat;

endmodule

`default_nettype wire

// ==== logic/pkt_buffer.sv ====
// packet store
// one write port driven by a strobe, one combinational read port.

`include "pkt_gen_cfg.svh"
`default_nettype none
`timescale 1ns/100ps

module pkt_buffer
    import axis_types_pkg::*;
    import pkt_gen_pkg::*;
(
    input  wire logic       axis_packet_out,
    input  wire logic       wr_strobe,
    input  wire word_addr_t wr_addr,
    input  wire axis_data_t wr_data,
    input  wire word_addr_t rd_addr,
    output axis_data_t      rd_data
);

    localparam int num_words = `PKT_GEN_MTU_BYTES / `PKT_GEN_DATA_BYTES;

    // lane i of a word is packet byte word*beat_width + i, lane 0 at the bottom.
    axis_data_t mem [num_words];

    always_ff @(posedge axis_packet_out) begin
        if (wr_strobe) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // the beat index drives rd_addr, so the word is ready in the same cycle.
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// ==== logic/pkt_gen_cfg.svh ====
// build-time configuration of the packet generator
// beat width, buffer capacity, user tag width and byte order.

`ifndef PKT_GEN_CFG_SVH
`define PKT_GEN_CFG_SVH

// bytes carried by one stream beat.
`define PKT_GEN_DATA_BYTES 4

// buffer capacity in bytes, also the longest packet.
// must be a whole number of beats.
`define PKT_GEN_MTU_BYTES 64

// width of the tuser tag.
`define PKT_GEN_USER_WIDTH 8

// 1 puts packet byte 0 of a beat in the top tdata lane.
// 0 puts it in the bottom lane.
`define PKT_GEN_BIG_ENDIAN 1

`endif

// ==== logic/pkt_gen_fsm.sv ====
// send control FSM
// request accept, busy and tvalid, and the beat advance pulse.

`default_nettype none
`timescale 1ns/100ps

module pkt_gen_fsm
    import pkt_gen_pkg::*;
(
    input  wire logic     axis_packet_out,
    input  wire logic     rst,
    input  wire logic     send_req,
    input  wire pkt_len_t pkt_len,
    input  wire logic     last_beat,
    input  wire logic     tready,
    output logic          accept,
    output logic          advance,
    output logic          busy,
    output logic          tvalid
);

    pkt_gen_state_t state;
    pkt_gen_state_t state_next;
    logic           xfer;

    // requests while busy or with zero length are dropped here.
    assign accept = (state == idle) && send_req && (pkt_len != '0);

    assign busy   = (state == send);
    assign tvalid = (state == send);

    assign xfer = tvalid && tready;

    // the counter holds on the final beat.
    assign advance = xfer && !last_beat;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_next = send;
                end
            end
            send: begin
                if (xfer && last_beat) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge axis_packet_out) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pkt_gen_pkg.sv ====
// generator-side types
// byte length, buffer word address, beat count and the FSM state.

`include "pkt_gen_cfg.svh"
`default_nettype none

package pkt_gen_pkg;

    // holds 0 up to the full buffer size.
    typedef logic [$clog2(`PKT_GEN_MTU_BYTES+1)-1:0] pkt_len_t;

    // index of one beat-wide word in the buffer.
    typedef logic [$clog2(`PKT_GEN_MTU_BYTES/`PKT_GEN_DATA_BYTES)-1:0] word_addr_t;

    // wide enough for the beat total of a full buffer.
    typedef logic [$clog2(`PKT_GEN_MTU_BYTES/`PKT_GEN_DATA_BYTES+1)-1:0] beat_cnt_t;

    typedef enum logic {
        idle,
        send
    } pkt_gen_state_t;

endpackage

`default_nettype wire

// ==== sim/tb_axis_packet_generator.sv ====
// testbench for the AXI4-Stream packet generator
// byte-array reference model, typed compare tasks, directed tests and a watchdog.

`include "pkt_gen_cfg.svh"
`default_nettype none
`timescale 1ns/100ps

module tb_axis_packet_generator
    import axis_types_pkg::*;
    import pkt_gen_pkg::*;
();

    localparam int data_bytes      = `PKT_GEN_DATA_BYTES;
    localparam int mtu_bytes       = `PKT_GEN_MTU_BYTES;
    localparam int num_words       = mtu_bytes / data_bytes;
    localparam int clk_period      = 8;
    // beats of all directed tests together.
    localparam int total_beats     = 39;
    localparam int watchdog_cycles = total_beats * 4 + 200;

    logic       axis_packet_out;
    logic       rst;
    logic       wr_strobe;
    word_addr_t wr_addr;
    axis_data_t wr_data;
    logic       send_req;
    pkt_len_t   pkt_len;
    axis_user_t pkt_user;
    logic       busy;
    logic       axis_packet_out_tvalid;
    axis_data_t axis_packet_out_tdata;
    axis_keep_t axis_packet_out_tkeep;
    axis_user_t axis_packet_out_tuser;
    logic       axis_packet_out_tlast;
    logic       axis_packet_out_tready;

    // packet bytes as the host wrote them.
    logic [7:0] ref_bytes [];

    axis_packet_generator u_axis_packet_generator (
        .axis_packet_out        (axis_packet_out),
        .rst                    (rst),
        .wr_strobe              (wr_strobe),
        .wr_addr                (wr_addr),
        .wr_data                (wr_data),
        .send_req               (send_req),
        .pkt_len                (pkt_len),
        .pkt_user               (pkt_user),
        .busy                   (busy),
        .axis_packet_out_tvalid (axis_packet_out_tvalid),
        .axis_packet_out_tdata  (axis_packet_out_tdata),
        .axis_packet_out_tkeep  (axis_packet_out_tkeep),
        .axis_packet_out_tuser  (axis_packet_out_tuser),
        .axis_packet_out_tlast  (axis_packet_out_tlast),
        .axis_packet_out_tready (axis_packet_out_tready)
    );

    initial axis_packet_out = 1'b0;
    always #(clk_period / 2) axis_packet_out = ~axis_packet_out;

    initial begin
        #(watchdog_cycles * clk_period);
        $display("ERROR: the run timed out after %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_data(input axis_data_t got, input axis_data_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "tdata compare");
        end
    endtask

    task automatic compare_keep(input axis_keep_t got, input axis_keep_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "tkeep compare");
        end
    endtask

    task automatic compare_user(input axis_user_t got, input axis_user_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "tuser compare");
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "bit compare");
        end
    endtask

    function automatic int beats_for(input int len);
        return len / data_bytes + ((len % data_bytes != 0) ? 1 : 0);
    endfunction

    // in big-endian order packet byte 0 is shifted in first and ends in the top lane.
    function automatic axis_data_t expected_data(input int beat);
        axis_data_t word;
        int         idx;
        word = '0;
        for (int i = 0; i < data_bytes; i++) begin
            idx  = (`PKT_GEN_BIG_ENDIAN != 0) ? i : data_bytes - 1 - i;
            word = (word << 8) | axis_data_t'(ref_bytes[beat * data_bytes + idx]);
        end
        return word;
    endfunction

    function automatic axis_keep_t expected_keep(input int beat, input int len);
        axis_keep_t keep;
        int         idx;
        keep = '0;
        for (int i = 0; i < data_bytes; i++) begin
            idx  = (`PKT_GEN_BIG_ENDIAN != 0) ? i : data_bytes - 1 - i;
            keep = (keep << 1) | axis_keep_t'(beat * data_bytes + idx < len);
        end
        return keep;
    endfunction

    task automatic wait_cycle();
        @(posedge axis_packet_out);
        #1;
    endtask

    task automatic write_word(input int addr, input axis_data_t data);
        axis_data_t tmp;
        wr_strobe = 1'b1;
        wr_addr   = word_addr_t'(addr);
        wr_data   = data;
        tmp       = data;
        for (int i = 0; i < data_bytes; i++) begin
            ref_bytes[addr * data_bytes + i] = tmp[7:0];
            tmp = tmp >> 8;
        end
        wait_cycle();
        wr_strobe = 1'b0;
    endtask

    task automatic fill_buffer();
        for (int w = 0; w < num_words; w++) begin
            write_word(w, axis_data_t'($urandom));
        end
    endtask

    task automatic request_send(input int len, input axis_user_t user);
        send_req = 1'b1;
        pkt_len  = pkt_len_t'(len);
        pkt_user = user;
        wait_cycle();
        send_req = 1'b0;
    endtask

    // starts right after the accepting edge and returns after the last transfer.
    task automatic receive_packet(input int len, input axis_user_t user, input int stall_pct);
        int         n_beats;
        int         beat;
        logic       stalled;
        axis_data_t held_data;
        axis_keep_t held_keep;
        axis_user_t held_user;
        logic       held_last;
        string      tag;
        n_beats = beats_for(len);
        beat    = 0;
        stalled = 1'b0;
        while (beat < n_beats) begin
            axis_packet_out_tready = ($urandom % 100) >= stall_pct;
            @(negedge axis_packet_out);
            if (axis_packet_out_tvalid !== 1'b1) begin
                report_failure($sformatf("tvalid is low before beat %0d of %0d", beat, n_beats));
            end
            tag = $sformatf("beat %0d", beat);
            if (stalled) begin
                compare_data(axis_packet_out_tdata, held_data, {tag, " tdata held"});
                compare_keep(axis_packet_out_tkeep, held_keep, {tag, " tkeep held"});
                compare_user(axis_packet_out_tuser, held_user, {tag, " tuser held"});
                compare_bit(axis_packet_out_tlast, held_last, {tag, " tlast held"});
            end
            compare_data(axis_packet_out_tdata, expected_data(beat), {tag, " tdata"});
            compare_keep(axis_packet_out_tkeep, expected_keep(beat, len), {tag, " tkeep"});
            compare_user(axis_packet_out_tuser, user, {tag, " tuser"});
            compare_bit(axis_packet_out_tlast, beat == n_beats - 1, {tag, " tlast"});
            held_data = axis_packet_out_tdata;
            held_keep = axis_packet_out_tkeep;
            held_user = axis_packet_out_tuser;
            held_last = axis_packet_out_tlast;
            stalled   = !axis_packet_out_tready;
            if (axis_packet_out_tready) begin
                beat++;
            end
            wait_cycle();
            send_req = 1'b0;
        end
        axis_packet_out_tready = 1'b1;
        compare_bit(busy, 1'b0, "busy after last transfer");
        compare_bit(axis_packet_out_tvalid, 1'b0, "tvalid after last transfer");
    endtask

    task automatic after_reset();
        compare_bit(busy, 1'b0, "busy after reset");
        compare_bit(axis_packet_out_tvalid, 1'b0, "tvalid after reset");
        compare_bit(axis_packet_out_tlast, 1'b0, "tlast after reset");
    endtask

    task automatic full_beat_packet();
        axis_user_t user;
        user = axis_user_t'($urandom);
        request_send(4 * data_bytes, user);
        compare_bit(busy, 1'b1, "busy after accept");
        receive_packet(4 * data_bytes, user, 0);
    endtask

    task automatic partial_last_beats();
        int         lens [4];
        axis_user_t user;
        lens = '{data_bytes + 1, data_bytes + 2, data_bytes + 3, 1};
        foreach (lens[k]) begin
            user = axis_user_t'($urandom);
            request_send(lens[k], user);
            receive_packet(lens[k], user, 0);
        end
    endtask

    task automatic stalled_stream();
        axis_user_t user;
        fill_buffer();
        user = axis_user_t'($urandom);
        request_send(5 * data_bytes + 3, user);
        receive_packet(5 * data_bytes + 3, user, 40);
    endtask

    task automatic ignored_requests();
        axis_user_t user;
        user = axis_user_t'($urandom);
        request_send(3 * data_bytes, user);
        // second request while busy with another length and tag.
        send_req = 1'b1;
        pkt_len  = pkt_len_t'(2 * data_bytes + 2);
        pkt_user = ~user;
        receive_packet(3 * data_bytes, user, 0);
        request_send(0, ~user);
        compare_bit(busy, 1'b0, "busy after zero-length request");
        repeat (3) begin
            @(negedge axis_packet_out);
            compare_bit(axis_packet_out_tvalid, 1'b0, "tvalid while idle");
            wait_cycle();
        end
        user = axis_user_t'($urandom);
        request_send(2 * data_bytes + 1, user);
        receive_packet(2 * data_bytes + 1, user, 0);
    endtask

    // tlast on the final word alone and tvalid low after it fix the beat count.
    task automatic full_buffer_packet();
        axis_user_t user;
        user = axis_user_t'($urandom);
        request_send(mtu_bytes, user);
        receive_packet(mtu_bytes, user, 0);
    endtask

    initial begin
        int unsigned seed_ret;
        seed_ret               = $urandom(51567);
        rst                    = 1'b1;
        wr_strobe              = 1'b0;
        wr_addr                = '0;
        wr_data                = '0;
        send_req               = 1'b0;
        pkt_len                = '0;
        pkt_user               = '0;
        axis_packet_out_tready = 1'b1;
        ref_bytes              = new[mtu_bytes];
        repeat (4) @(posedge axis_packet_out);
        #1;
        rst = 1'b0;
        after_reset();
        fill_buffer();
        full_beat_packet();
        partial_last_beats();
        stalled_stream();
        ignored_requests();
        full_buffer_packet();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
